//--- bench/spi_master_properties.sv
`timescale 1ns/10ps

module spi_master_properties (
    input logic clk,
    input logic rst_n,
    input logic tx_ready,
    input logic rx_valid,
    input logic spi_clk,
    input logic spi_cs_n
);

    // Mode 0 clock idles low outside a frame
    clk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        spi_cs_n |-> !spi_clk)
        else $error("spi_clk high while chip select is released");

    rx_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held for more than one cycle");

    // Host may not offer a byte during a frame
    ready_outside_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_ready && !spi_cs_n))
        else $error("tx_ready high while chip select is low");

    cs_release_then_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(spi_cs_n) |=> rx_valid)
        else $error("chip select released without rx_valid following");

    no_valid_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !spi_cs_n |-> !rx_valid)
        else $error("rx_valid raised while chip select is still low");

endmodule

bind spi_master_top spi_master_properties u_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_ready (tx_ready),
    .rx_valid (rx_valid),
    .spi_clk  (spi_clk),
    .spi_cs_n (spi_cs_n)
);

//--- bench/spi_master_tb.sv
`timescale 1ns/10ps

module spi_master_tb;

    localparam int HP           = 3;
    localparam int FRAME_CYCLES = 16 * HP + 2;  // Accepting edge to rx_valid
    localparam int NUM_FRAMES   = 23;
    localparam int WATCHDOG_NS  = (NUM_FRAMES + 10) * FRAME_CYCLES * 20;
    localparam int WAIT_LIMIT   = 4 * FRAME_CYCLES;

    logic                     clk;
    logic                     rst_n;
    spi_types_pkg::spi_word_t tx_data;
    logic                     tx_valid;
    logic                     tx_ready;
    spi_types_pkg::spi_word_t rx_data;
    logic                     rx_valid;
    logic                     spi_clk;
    logic                     spi_mosi;
    logic                     spi_miso;
    logic                     spi_cs_n;

    // Slave model state
    spi_types_pkg::spi_word_t slave_reply;  // Returned in the next frame
    spi_types_pkg::spi_word_t slave_out;
    spi_types_pkg::spi_word_t slave_in;     // MOSI bits seen this frame
    int                       rise_count;

    int     errors;
    integer seed;

    spi_master_top #(
        .HALF_PERIOD (HP)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .spi_cs_n (spi_cs_n)
    );

    always #10 clk = ~clk;

    // Mode 0 slave, reply MSB ready as soon as it is selected
    always @(negedge spi_cs_n) begin
        slave_out  = slave_reply;
        slave_in   = '0;
        rise_count = 0;
        spi_miso   = slave_out[7];
    end

    always @(posedge spi_clk) begin
        if (!spi_cs_n) begin
            slave_in   = {slave_in[6:0], spi_mosi};
            rise_count = rise_count + 1;
        end
    end

    always @(negedge spi_clk) begin
        if (!spi_cs_n) begin
            slave_out = {slave_out[6:0], 1'b0};
            spi_miso  = slave_out[7];
        end
    end

    // Drive and sample point, just after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        errors = errors + 1;
        $display("Fail %s %s: expected %0h, actual %0h", test, what, expected, actual);
    endtask

    // One framed byte, optionally with a stray strobe poke_at cycles into the frame
    task automatic run_frame(input string test, input spi_types_pkg::spi_word_t tx_byte,
                             input spi_types_pkg::spi_word_t reply, input int poke_at,
                             output int latency);
        int waited;
        waited  = 0;
        latency = 0;
        while (!tx_ready && waited < WAIT_LIMIT) begin
            step_clock();
            waited = waited + 1;
        end
        if (!tx_ready) begin
            errors = errors + 1;
            $display("%s: tx_ready never came back high", test);
            return;
        end
        slave_reply = reply;
        tx_data     = tx_byte;
        tx_valid    = 1'b1;
        step_clock();  // Accepting edge
        while (!rx_valid && latency < WAIT_LIMIT) begin
            tx_valid = (latency == poke_at);
            if (latency == poke_at) begin
                tx_data = ~tx_byte;
            end
            step_clock();
            latency = latency + 1;
        end
        tx_valid = 1'b0;
        if (!rx_valid) begin
            errors = errors + 1;
            $display("%s: rx_valid never arrived after the byte was accepted", test);
            return;
        end
        if (slave_in !== tx_byte) begin
            report_mismatch(test, "mosi byte", 32'(tx_byte), 32'(slave_in));
        end
        if (rx_data !== reply) begin
            report_mismatch(test, "rx_data", 32'(reply), 32'(rx_data));
        end
    endtask

    task automatic test_reset_values();
        if (tx_ready !== 1'b1) report_mismatch("reset_values", "tx_ready", 1, 32'(tx_ready));
        if (spi_cs_n !== 1'b1) report_mismatch("reset_values", "spi_cs_n", 1, 32'(spi_cs_n));
        if (spi_clk !== 1'b0) report_mismatch("reset_values", "spi_clk", 0, 32'(spi_clk));
        if (spi_mosi !== 1'b0) report_mismatch("reset_values", "spi_mosi", 0, 32'(spi_mosi));
        if (rx_valid !== 1'b0) report_mismatch("reset_values", "rx_valid", 0, 32'(rx_valid));
        if (rx_data !== 8'h00) report_mismatch("reset_values", "rx_data", 0, 32'(rx_data));
    endtask

    task automatic test_single_transfer();
        int latency;
        run_frame("single_transfer", 8'hA5, 8'h3C, -1, latency);
    endtask

    task automatic test_latency();
        int latency;
        run_frame("latency", 8'h5A, 8'hC3, -1, latency);
        if (latency != FRAME_CYCLES) report_mismatch("latency", "cycles", FRAME_CYCLES, latency);
        if (rise_count != 8) report_mismatch("latency", "spi_clk rises", 8, rise_count);
    endtask

    task automatic test_ignored_strobe();
        int latency;
        int pulses;
        bit cs_seen;
        run_frame("ignored_strobe", 8'h96, 8'h4E, 20, latency);
        pulses  = rx_valid ? 1 : 0;
        cs_seen = 1'b0;
        repeat (FRAME_CYCLES) begin  // Long enough for a queued frame to show
            step_clock();
            if (rx_valid) pulses = pulses + 1;
            if (!spi_cs_n) cs_seen = 1'b1;
        end
        if (pulses != 1) report_mismatch("ignored_strobe", "rx_valid pulses", 1, pulses);
        if (cs_seen) begin
            errors = errors + 1;
            $display("ignored_strobe: the mid-frame strobe started another frame");
        end
    endtask

    task automatic test_random_frames();
        spi_types_pkg::spi_word_t tx_byte;
        spi_types_pkg::spi_word_t reply;
        int                       latency;
        for (int i = 0; i < 20; i++) begin
            tx_byte = spi_types_pkg::spi_word_t'($random(seed));
            reply   = spi_types_pkg::spi_word_t'($random(seed));
            run_frame("random_frames", tx_byte, reply, -1, latency);
            if (latency != FRAME_CYCLES) begin
                report_mismatch("random_frames", "cycles", FRAME_CYCLES, latency);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        tx_data     = '0;
        tx_valid    = 1'b0;
        spi_miso    = 1'b0;
        slave_reply = '0;
        slave_out   = '0;
        slave_in    = '0;
        rise_count  = 0;
        errors      = 0;
        seed        = 32'hbf7a203a;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_values();
        test_single_transfer();
        test_latency();
        test_ignored_strobe();
        test_random_frames();
        $display("Tests complete: %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert --top-module spi_master_tb \
    -f spi_master.f -o spi_master_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/spi_master_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$SIM_LOG"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

//--- source/spi_ctrl_pkg.sv
package spi_ctrl_pkg;

    // Transfer sequencing
    typedef enum logic [1:0] {
        IDLE   = 2'b00,  // Waiting for a byte, chip select high
        ACTIVE = 2'b01,  // Clocking the byte out and in
        DONE   = 2'b10   // Chip select released, result captured
    } xfer_state_t;

    // Single-cycle strobes that steer the datapath
    // Each one takes effect on the clk edge that ends its cycle
    typedef struct packed {
        logic load;     // Take tx_data, drive its MSB
        logic sample;   // Pull spi_miso into the receive register
        logic shift;    // Move the next transmit bit onto MOSI
        logic capture;  // Hand the received byte to the host
    } shift_ctrl_t;

endpackage

//--- source/spi_half_period_timer.sv
`timescale 1ns/10ps

module spi_half_period_timer #(
    parameter int HALF_PERIOD = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic half_tick,
    output logic last_half
);

    // A single bit is enough when every cycle is a tick
    localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF_PERIOD - 1);

    localparam spi_types_pkg::half_count_t LAST_HALF =
        spi_types_pkg::half_count_t'(spi_types_pkg::FRAME_HALVES - 1);

    logic [CNT_W-1:0]           cycle_cnt;
    logic                       wrap;
    spi_types_pkg::half_count_t half_cnt;

    assign wrap = (cycle_cnt == CNT_LAST);

    // Cycle pacing within one half period
    // The tick is registered, so it shows HALF_PERIOD cycles after run rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            half_tick <= 1'b0;
        end else if (!run) begin
            cycle_cnt <= '0;  // Realign for the next frame
            half_tick <= 1'b0;
        end else begin
            half_tick <= wrap;
            cycle_cnt <= wrap ? '0 : cycle_cnt + 1'b1;
        end
    end

    // Half periods completed in this frame, bumped as each tick is used
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
        end else if (!run) begin
            half_cnt <= '0;
        end else if (half_tick) begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // High from the 15th tick until the 16th
    assign last_half = (half_cnt == LAST_HALF);

endmodule

//--- source/spi_master_top.sv
`timescale 1ns/10ps

module spi_master_top #(
    parameter int HALF_PERIOD = 2  // clk cycles per SPI clock half period
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  spi_types_pkg::spi_word_t tx_data,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    output spi_types_pkg::spi_word_t rx_data,
    output logic                     rx_valid,
    output logic                     spi_clk,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     spi_cs_n
);

    logic                       run;
    logic                       half_tick;
    logic                       last_half;
    spi_ctrl_pkg::shift_ctrl_t  shift_ctrl;
    spi_types_pkg::shift_data_t shift_data;

    // Paces the SPI clock
    spi_half_period_timer #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .half_tick (half_tick),
        .last_half (last_half)
    );

    spi_transfer_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_valid  (tx_valid),
        .half_tick (half_tick),
        .last_half (last_half),
        .run       (run),
        .ctrl      (shift_ctrl),
        .tx_ready  (tx_ready),
        .rx_valid  (rx_valid),
        .spi_clk   (spi_clk),
        .spi_cs_n  (spi_cs_n)
    );

    spi_shift_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .spi_miso (spi_miso),
        .ctrl     (shift_ctrl),
        .data     (shift_data),
        .rx_data  (rx_data)
    );

    assign spi_mosi = shift_data.mosi;

endmodule

//--- source/spi_shift_datapath.sv
`timescale 1ns/10ps

module spi_shift_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  spi_types_pkg::spi_word_t   tx_data,
    input  logic                       spi_miso,
    input  spi_ctrl_pkg::shift_ctrl_t  ctrl,
    output spi_types_pkg::shift_data_t data,
    output spi_types_pkg::spi_word_t   rx_data
);

    localparam int TOP = spi_types_pkg::WORD_BITS - 1;

    spi_types_pkg::spi_word_t tx_shift;
    spi_types_pkg::spi_word_t rx_shift;

    // Transmit register, MSB always on the wire
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
        end else if (ctrl.load) begin
            tx_shift <= tx_data;
        end else if (ctrl.shift) begin
            tx_shift <= {tx_shift[TOP-1:0], 1'b0};
        end else if (ctrl.capture) begin
            tx_shift <= '0;  // MOSI back low once the byte is out
        end
    end

    // Receive register, MISO enters at bit 0
    always_ff @(posedge clk) begin
        if (ctrl.sample) begin
            rx_shift <= {rx_shift[TOP-1:0], spi_miso};
        end
    end

    // Result held for the host until the next frame completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_data <= '0;
        end else if (ctrl.capture) begin
            rx_data <= rx_shift;
        end
    end

    always_comb begin
        data         = '0;
        data.mosi    = tx_shift[TOP];
        data.rx_byte = rx_shift;  // Full byte once the 8th sample is in
    end

endmodule

//--- source/spi_transfer_fsm.sv
`timescale 1ns/10ps

module spi_transfer_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tx_valid,
    input  logic                      half_tick,
    input  logic                      last_half,
    output logic                      run,
    output spi_ctrl_pkg::shift_ctrl_t ctrl,
    output logic                      tx_ready,
    output logic                      rx_valid,
    output logic                      spi_clk,
    output logic                      spi_cs_n
);

    spi_ctrl_pkg::xfer_state_t state;
    spi_ctrl_pkg::xfer_state_t state_next;

    logic active;
    logic edge_due;  // A clock toggle lands on the coming edge

    assign active   = (state == spi_ctrl_pkg::ACTIVE);
    assign edge_due = active && half_tick;

    assign run      = active;                      // Timer only counts inside a frame
    assign tx_ready = (state == spi_ctrl_pkg::IDLE);

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            spi_ctrl_pkg::IDLE: begin
                if (tx_valid) begin
                    state_next = spi_ctrl_pkg::ACTIVE;
                end
            end
            spi_ctrl_pkg::ACTIVE: begin
                // 16th toggle brings the clock back low and ends the byte
                if (half_tick && last_half) begin
                    state_next = spi_ctrl_pkg::DONE;
                end
            end
            spi_ctrl_pkg::DONE: begin
                state_next = spi_ctrl_pkg::IDLE;
            end
            default: begin
                state_next = spi_ctrl_pkg::IDLE;
            end
        endcase
    end

    // Datapath strobes, decoded from the present state and tick
    always_comb begin
        ctrl         = '0;
        ctrl.load    = tx_ready && tx_valid;
        ctrl.sample  = edge_due && !spi_clk;               // Rising edge of spi_clk
        ctrl.shift   = edge_due && spi_clk && !last_half;  // Falling edge, not the final one
        ctrl.capture = (state == spi_ctrl_pkg::DONE);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= spi_ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Chip select is low exactly while the next state is ACTIVE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_cs_n <= 1'b1;
        end else begin
            spi_cs_n <= (state_next != spi_ctrl_pkg::ACTIVE);
        end
    end

    // SPI clock phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_clk <= 1'b0;
        end else if (edge_due) begin
            spi_clk <= ~spi_clk;
        end else if (!active) begin
            spi_clk <= 1'b0;  // Idle low between frames
        end
    end

    // One pulse, the edge after the result is captured
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= ctrl.capture;
        end
    end

endmodule

//--- source/spi_types_pkg.sv
package spi_types_pkg;

    // Frame geometry for mode 0, MSB first
    localparam int WORD_BITS    = 8;
    localparam int FRAME_HALVES = 2 * WORD_BITS;  // SPI clock half periods per byte

    // One byte on the wire
    typedef logic [WORD_BITS-1:0] spi_word_t;

    // Half periods elapsed in a frame, 0 to 16
    typedef logic [4:0] half_count_t;

    // What the datapath shows of the frame in flight
    typedef struct packed {
        logic      mosi;     // Bit currently driven to the slave
        spi_word_t rx_byte;  // Bits gathered so far, MSB first
    } shift_data_t;

endpackage

//--- spi_master.f
source/spi_types_pkg.sv
source/spi_ctrl_pkg.sv
source/spi_half_period_timer.sv
source/spi_transfer_fsm.sv
source/spi_shift_datapath.sv
source/spi_master_top.sv
bench/spi_master_properties.sv
bench/spi_master_tb.sv
